// ==== verilog/i2s_pkg.sv ====
`default_nettype none

package i2s_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data widths
    //////////////////////////////////////////////////////////////////////

    localparam int SAMPLE_W = 16;               // One audio channel
    localparam int FRAME_W  = 2 * SAMPLE_W;     // Left in upper half, right in lower half

    // BIST start value, upper limit and running counter
    localparam int BIST_W   = 12;

    //////////////////////////////////////////////////////////////////////
    // Deserializer FSM
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        des_idle,                               // Waiting for the end of a right word
        des_left,                               // Collecting the left word
        des_right                               // Collecting the right word
    } des_state_t;

endpackage

`default_nettype wire

// ==== verilog/i2s_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module i2s_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic sck,                   // Bit clock from the pin
    input  logic ws,                    // Word select from the pin
    input  logic sd,                    // Serial data from the pin
    output logic sck_rise,              // One clk pulse per rising bit clock edge
    output logic sync_ws,
    output logic sync_sd
);

    // All three vectors are packed as {sck, ws, sd}
    logic [2:0] pin_meta;               // First stage, may go metastable
    logic [2:0] pin_sync;               // Second stage, safe to use
    logic [2:0] pin_dly;                // Third stage, aligns ws and sd with sck_rise

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pin_meta <= '0;
            pin_sync <= '0;
            pin_dly  <= '0;
            sck_rise <= 1'b0;
        end
        else
        begin
            pin_meta <= {sck, ws, sd};
            pin_sync <= pin_meta;
            pin_dly  <= pin_sync;
            sck_rise <= pin_sync[2] & ~pin_dly[2];  // New sck high, old sck low
        end
    end

    // ws and sd leave from the same stage that clocks sck_rise
    assign sync_ws = pin_dly[1];
    assign sync_sd = pin_dly[0];

endmodule

`default_nettype wire

// ==== verilog/i2s_deserializer.sv ====
`timescale 1ns/100ps
`default_nettype none

module i2s_deserializer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sck_rise,   // Sample strobe from the synchronizer
    input  logic                        ws,         // 0 = left, 1 = right
    input  logic                        sd,
    input  logic                        enable,
    output logic [i2s_pkg::FRAME_W-1:0] frame,      // {left, right}
    output logic                        xfc         // One clk per stereo frame
);

    import i2s_pkg::*;

    des_state_t          state;
    logic [SAMPLE_W-1:0] shift_q;       // Last SAMPLE_W bits seen on sd
    logic [SAMPLE_W-1:0] shift_nxt;
    logic [SAMPLE_W-1:0] left_q;        // Completed left word
    logic                ws_prev;       // ws at the previous bit
    logic                ws_fall;       // Right word ends with this bit
    logic                ws_rise;       // Left word ends with this bit
    logic                emit;

    // The bit sampled together with a changed ws is still the LSB
    // of the word that ws has just left
    assign shift_nxt = {shift_q[SAMPLE_W-2:0], sd};
    assign ws_fall   = sck_rise & ws_prev & ~ws;
    assign ws_rise   = sck_rise & ~ws_prev & ws;
    assign emit      = enable & (state == des_right) & ws_fall;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= des_idle;
            ws_prev <= 1'b0;
            xfc     <= 1'b0;
        end
        else
        begin
            xfc <= emit;
            if (sck_rise)
                ws_prev <= ws;                  // Tracked even while disabled

            if (!enable)
                state <= des_idle;
            else
            begin
                case (state)
                    des_idle:
                        if (ws_fall)
                            state <= des_left;  // Next bit is a left MSB
                    des_left:
                        if (ws_rise)
                            state <= des_right;
                    des_right:
                        if (ws_fall)
                            state <= des_left;
                    default:
                        state <= des_idle;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (sck_rise)
            shift_q <= shift_nxt;
        if (ws_rise && state == des_left)
            left_q <= shift_nxt;
        if (emit)
            frame <= {left_q, shift_nxt};
    end

endmodule

`default_nettype wire

// ==== verilog/i2s_bist_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module i2s_bist_gen (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sck_rise,
    input  logic                        run,
    input  logic [i2s_pkg::BIST_W-1:0]  start_val,
    input  logic [7:0]                  inc,
    input  logic [i2s_pkg::BIST_W-1:0]  up_limit,
    output logic [i2s_pkg::FRAME_W-1:0] frame,
    output logic                        xfc
);

    import i2s_pkg::*;

    localparam int EDGE_W = 5;          // 32 bit clocks per stereo frame

    logic [EDGE_W-1:0]   edge_cnt;
    logic [BIST_W-1:0]   cnt_q;
    logic                cnt_live;      // Low until the first frame, counter reads start_val
    logic [BIST_W-1:0]   cnt_cur;
    logic [BIST_W:0]     cnt_sum;       // One extra bit catches the 12 bit overflow
    logic [BIST_W-1:0]   cnt_nxt;
    logic [SAMPLE_W-1:0] sample;
    logic                fire;

    assign cnt_cur = cnt_live ? cnt_q : start_val;
    assign cnt_sum = {1'b0, cnt_cur} + {{(BIST_W + 1 - 8){1'b0}}, inc};
    assign cnt_nxt = (cnt_sum[BIST_W] || cnt_sum[BIST_W-1:0] > up_limit) ?
                     start_val : cnt_sum[BIST_W-1:0];
    assign sample  = {{(SAMPLE_W - BIST_W){1'b0}}, cnt_cur};
    assign fire    = run & sck_rise & (edge_cnt == '1);  // 32nd edge

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            edge_cnt <= '0;
            cnt_q    <= '0;
            cnt_live <= 1'b0;
            xfc      <= 1'b0;
        end
        else if (!run)
        begin
            edge_cnt <= '0;
            cnt_live <= 1'b0;                   // Restart from start_val
            xfc      <= 1'b0;
        end
        else
        begin
            xfc <= fire;
            if (sck_rise)
                edge_cnt <= edge_cnt + 1'b1;    // Wraps every 32 edges
            if (fire)
            begin
                cnt_q    <= cnt_nxt;
                cnt_live <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fire)
            frame <= {sample, sample};          // Same count in both channels
    end

endmodule

`default_nettype wire

// ==== verilog/i2s_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module i2s_fifo #(
    parameter int FIFO_AW = 3
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [i2s_pkg::FRAME_W-1:0] inp_data,
    input  logic                        inp_rts,    // Source strobe
    output logic                        inp_rtr,    // Not full
    output logic [i2s_pkg::FRAME_W-1:0] out_data,   // Head entry, no read latency
    output logic                        out_rts,    // Not empty
    input  logic                        out_rtr     // Consumer takes the head
);

    import i2s_pkg::*;

    localparam int DEPTH = 1 << FIFO_AW;

    logic [FRAME_W-1:0] mem [DEPTH];
    logic [FIFO_AW:0]   wr_ptr;         // MSB is the wrap bit
    logic [FIFO_AW:0]   rd_ptr;
    logic               full;
    logic               empty;
    logic               do_wr;
    logic               do_rd;

    //////////////////////////////////////////////////////////////////////
    // Status
    //////////////////////////////////////////////////////////////////////

    // Same index with different wrap bits means the writer is a lap ahead
    assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign inp_rtr  = ~full;
    assign out_rts  = ~empty;
    assign out_data = mem[rd_ptr[FIFO_AW-1:0]];

    assign do_wr = inp_rts & inp_rtr;   // Strobe while full is dropped
    assign do_rd = out_rts & out_rtr;

    //////////////////////////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr[FIFO_AW-1:0]] <= inp_data;
    end

endmodule

`default_nettype wire

// ==== verilog/i2s_in.sv ====
`timescale 1ns/100ps
`default_nettype none

module i2s_in #(
    parameter int FIFO_AW = 3
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sck,            // I2S bit clock, async to clk
    input  logic                        ws,
    input  logic                        sd,
    input  logic                        i2s_en,         // Deserializer enable
    input  logic                        mux_en,         // 1 selects BIST as source
    input  logic [i2s_pkg::BIST_W-1:0]  bist_start,
    input  logic [7:0]                  bist_inc,
    input  logic [i2s_pkg::BIST_W-1:0]  bist_limit,
    input  logic                        out_rtr,
    output logic [i2s_pkg::FRAME_W-1:0] out_data,
    output logic                        out_rts,
    input  logic                        overrun_clr,
    output logic                        overrun         // Sticky, frame lost on full FIFO
);

    import i2s_pkg::*;

    logic               sck_rise;
    logic               sync_ws;
    logic               sync_sd;

    logic [FRAME_W-1:0] des_frame;
    logic               des_xfc;
    logic [FRAME_W-1:0] bist_frame;
    logic               bist_xfc;

    logic [FRAME_W-1:0] src_frame;      // Selected source into the FIFO
    logic               src_xfc;
    logic               fifo_rtr;

    //////////////////////////////////////////////////////////////////////
    // Frame sources
    //////////////////////////////////////////////////////////////////////

    i2s_sync u_sync (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck      (sck),
        .ws       (ws),
        .sd       (sd),
        .sck_rise (sck_rise),
        .sync_ws  (sync_ws),
        .sync_sd  (sync_sd)
    );

    i2s_deserializer u_des (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck_rise (sck_rise),
        .ws       (sync_ws),
        .sd       (sync_sd),
        .enable   (i2s_en),
        .frame    (des_frame),
        .xfc      (des_xfc)
    );

    i2s_bist_gen u_bist (
        .clk       (clk),
        .rst_n     (rst_n),
        .sck_rise  (sck_rise),
        .run       (mux_en),
        .start_val (bist_start),
        .inc       (bist_inc),
        .up_limit  (bist_limit),
        .frame     (bist_frame),
        .xfc       (bist_xfc)
    );

    assign src_frame = mux_en ? bist_frame : des_frame;
    assign src_xfc   = mux_en ? bist_xfc : des_xfc;

    //////////////////////////////////////////////////////////////////////
    // Buffer and overrun
    //////////////////////////////////////////////////////////////////////

    i2s_fifo #(
        .FIFO_AW (FIFO_AW)
    ) u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .inp_data (src_frame),
        .inp_rts  (src_xfc),
        .inp_rtr  (fifo_rtr),
        .out_data (out_data),
        .out_rts  (out_rts),
        .out_rtr  (out_rtr)
    );

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            overrun <= 1'b0;
        else if (src_xfc && !fifo_rtr)
            overrun <= 1'b1;            // Set wins over a clear in the same clk
        else if (overrun_clr)
            overrun <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/tb_i2s_in.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_i2s_in;

    import i2s_pkg::*;

    localparam int FIFO_AW   = 3;
    localparam int DEPTH     = 1 << FIFO_AW;
    localparam int PAT_WORDS = 256;             // Five words per record
    localparam int DRAIN_MAX = 2000;            // clk cycles allowed for the FIFO to empty

    logic               clk = 1'b0;
    logic               rst_n;
    logic               sck;
    logic               ws;
    logic               sd;
    logic               i2s_en;
    logic               mux_en;
    logic [BIST_W-1:0]  bist_start;
    logic [7:0]         bist_inc;
    logic [BIST_W-1:0]  bist_limit;
    logic               out_rtr = 1'b0;
    logic [FRAME_W-1:0] out_data;
    logic               out_rts;
    logic               overrun_clr;
    logic               overrun;

    logic [FRAME_W-1:0] exp_q [$];              // Frames still owed by the DUT
    logic [FRAME_W-1:0] exp_frame;
    logic [31:0]        pat [0:PAT_WORDS-1];
    int                 rtr_mode    = 0;        // 0 ready, 1 random, 2 held low
    int                 wd_ns       = 0;
    int                 main_errs   = 0;
    int                 cons_errs   = 0;
    int                 cons_checks = 0;
    logic               quiet_watch = 1'b0;
    logic               quiet_bad   = 1'b0;
    logic               i2s_on      = 1'b0;     // Deserializer armed by a lead-in frame

    i2s_in #(
        .FIFO_AW (FIFO_AW)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .sck         (sck),
        .ws          (ws),
        .sd          (sd),
        .i2s_en      (i2s_en),
        .mux_en      (mux_en),
        .bist_start  (bist_start),
        .bist_inc    (bist_inc),
        .bist_limit  (bist_limit),
        .out_rtr     (out_rtr),
        .out_data    (out_data),
        .out_rts     (out_rts),
        .overrun_clr (overrun_clr),
        .overrun     (overrun)
    );

    always #10 clk = ~clk;                      // 20 ns period

    //////////////////////////////////////////////////////////////////////
    // Consumer side
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin : rtr_drive
        logic [31:0] rnd;
        if (rtr_mode == 1)
        begin
            rnd = $urandom();
            out_rtr <= rnd[0];
        end
        else
            out_rtr <= (rtr_mode == 0);
    end

    always @(posedge clk)
    begin
        if (rst_n && out_rts && out_rtr)        // A frame leaves the FIFO at this edge
        begin
            cons_checks++;
            if (exp_q.size() == 0)
            begin
                $display("Unexpected frame %h at %0t when no frame was owed", out_data, $time);
                cons_errs++;
            end
            else
            begin
                exp_frame = exp_q.pop_front();
                if (out_data !== exp_frame)
                begin
                    $display("ERR %0t: frame %h, expected %h", $time, out_data, exp_frame);
                    cons_errs++;
                end
            end
        end
    end

    always @(negedge clk)
    begin
        if (quiet_watch && !quiet_bad && (out_rts !== 1'b0 || overrun !== 1'b0))
        begin
            $display("ERR %0t: output activity while i2s_en was low", $time);
            quiet_bad = 1'b1;
            main_errs++;
        end
    end

    initial
    begin
        wait (wd_ns > 0);
        #(wd_ns);
        $display("Timeout: the run did not finish within %0d ns", wd_ns);
        $display("Result: FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic int total_errs();
        return main_errs + cons_errs;
    endfunction

    // One bit slot, sck low for 4 clk then high for 4 clk
    task send_bit(input logic w, input logic b);
        @(posedge clk);
        sck <= 1'b0;
        ws  <= w;
        sd  <= b;
        repeat (4) @(posedge clk);
        sck <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    // ws flips on the LSB slot, one bit ahead of the next word's MSB
    task send_frame(input logic [SAMPLE_W-1:0] left, input logic [SAMPLE_W-1:0] right);
        logic [FRAME_W-1:0] bits;
        int                 i;
        bits = {left, right};
        for (i = 0; i < FRAME_W; i++)
        begin
            if (i < SAMPLE_W)
                send_bit(i == SAMPLE_W - 1, bits[FRAME_W-1]);
            else
                send_bit(i != FRAME_W - 1, bits[FRAME_W-1]);
            bits = bits << 1;
        end
    endtask

    task enable_i2s();
        if (!i2s_on)
        begin
            @(posedge clk);
            i2s_en <= 1'b1;
            i2s_on = 1'b1;
            send_frame('0, '0);                 // Lead-in, only its final ws fall counts
        end
    endtask

    task push_bist(input logic [BIST_W-1:0] start, input logic [7:0] inc,
                   input logic [BIST_W-1:0] limit, input int n);
        int                  val;
        logic [SAMPLE_W-1:0] half;
        int                  k;
        val = int'(start);
        for (k = 0; k < n; k++)
        begin
            half = val[SAMPLE_W-1:0];           // Count fits in 12 bits, upper bits zero
            exp_q.push_back({half, half});
            val = val + int'(inc);
            if (val > int'(limit) || val >= (1 << BIST_W))
                val = int'(start);              // Past the limit or out of 12 bits
        end
    endtask

    task wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_MAX)
        begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0)
        begin
            $display("Frames missing: %0d still owed after %0d cycles", exp_q.size(), n);
            main_errs++;
            exp_q.delete();
        end
    endtask

    task report_test(input int num, input string name, input int errs_before);
        if (total_errs() == errs_before)
            $display("Test %0d %s: ok", num, name);
        else
            $display("Test %0d %s: %0d errors", num, name, total_errs() - errs_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [7:0]  idx;
        logic [31:0] kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] rnd;
        int          frames;
        int          n;
        int          test_no;
        int          errs_start;
        rnd         = $urandom(32'h1a873785);
        rst_n       <= 1'b0;
        sck         <= 1'b1;
        ws          <= 1'b0;
        sd          <= 1'b0;
        i2s_en      <= 1'b0;
        mux_en      <= 1'b0;
        bist_start  <= '0;
        bist_inc    <= '0;
        bist_limit  <= '0;
        overrun_clr <= 1'b0;
        $readmemh("test/i2s_in_patterns.txt", pat);

        frames = 2;                             // Frames of the disabled-input test
        for (idx = 0; pat[idx] != 32'hf; idx = idx + 8'd5)
            frames = frames + 1 + (pat[idx] == 32'd1 ? pat[idx+8'd4] :
                                   (pat[idx] == 32'd2 ? pat[idx+8'd2] : 32'd0));
        wd_ns = frames * 32 * 160 * 4;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_no    = 1;
        errs_start = total_errs();
        @(negedge clk);
        if (out_rts !== 1'b0 || overrun !== 1'b0)
        begin
            $display("ERR %0t: out_rts or overrun high after reset", $time);
            main_errs++;
        end
        quiet_watch = 1'b1;
        send_frame(16'h1357, 16'h2468);
        send_frame(16'h0f0f, 16'hf0f0);
        repeat (8) @(posedge clk);              // Past the 5 clk pin to FIFO latency
        quiet_watch = 1'b0;
        report_test(test_no, "reset and disabled input", errs_start);

        idx = 0;
        while (pat[idx] != 32'hf)
        begin
            kind       = pat[idx];
            a          = pat[idx+8'd1];
            b          = pat[idx+8'd2];
            c          = pat[idx+8'd3];
            d          = pat[idx+8'd4];
            test_no    = test_no + 1;
            errs_start = total_errs();
            if (kind == 32'd0)
            begin
                enable_i2s();
                exp_q.push_back({a[15:0], b[15:0]});
                send_frame(a[15:0], b[15:0]);
                wait_drained();
                report_test(test_no, "I2S frame", errs_start);
            end
            else if (kind == 32'd1)
            begin
                @(posedge clk);
                i2s_en     <= 1'b0;
                i2s_on     = 1'b0;
                bist_start <= a[BIST_W-1:0];
                bist_inc   <= b[7:0];
                bist_limit <= c[BIST_W-1:0];
                @(posedge clk);
                mux_en <= 1'b1;
                push_bist(a[BIST_W-1:0], b[7:0], c[BIST_W-1:0], d);
                for (n = 0; n < d; n++)
                    send_frame('0, '0);         // 32 bit clocks per BIST frame
                wait_drained();
                @(posedge clk);
                mux_en <= 1'b0;
                report_test(test_no, "BIST sequence", errs_start);
            end
            else if (a == 32'd0)
            begin
                enable_i2s();
                @(negedge clk);
                rtr_mode = 1;
                for (n = 0; n < b; n++)
                begin
                    rnd = $urandom();
                    exp_q.push_back(rnd);
                    send_frame(rnd[31:16], rnd[15:0]);
                end
                wait_drained();
                rtr_mode = 0;
                if (overrun !== 1'b0)
                begin
                    $display("ERR %0t: overrun set under random out_rtr", $time);
                    main_errs++;
                end
                report_test(test_no, "random out_rtr", errs_start);
            end
            else
            begin
                enable_i2s();
                @(negedge clk);
                rtr_mode = 2;
                for (n = 0; n < b; n++)
                begin
                    rnd = $urandom();
                    if (n < DEPTH)
                        exp_q.push_back(rnd);   // Later frames find the FIFO full
                    send_frame(rnd[31:16], rnd[15:0]);
                end
                repeat (8) @(posedge clk);
                @(negedge clk);
                if (overrun !== 1'b1 || out_rts !== 1'b1)
                begin
                    $display("ERR %0t: overrun %b out_rts %b with FIFO full", $time,
                             overrun, out_rts);
                    main_errs++;
                end
                rtr_mode = 0;
                wait_drained();
                @(negedge clk);
                if (out_rts !== 1'b0)
                begin
                    $display("ERR %0t: FIFO not empty after its stored frames", $time);
                    main_errs++;
                end
                @(posedge clk);
                overrun_clr <= 1'b1;
                @(posedge clk);
                overrun_clr <= 1'b0;
                @(negedge clk);
                if (overrun !== 1'b0)
                begin
                    $display("ERR %0t: overrun still high after overrun_clr", $time);
                    main_errs++;
                end
                report_test(test_no, "out_rtr held low", errs_start);
            end
            idx = idx + 8'd5;
        end

        $display("Tests: %0d, frames checked: %0d, errors: %0d", test_no, cons_checks,
                 total_errs());
        if (total_errs() == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/i2s_in_patterns.txt ====
// Columns in hex: kind a b c d. Kind 0 sends one I2S frame, a = left, b = right
// Kind 1 runs BIST, a = start, b = inc, c = limit, d = frames. Kind 2 stalls, a = 0 random rtr
// or 1 rtr held low, b = frames. Kind f ends the list
0 1234 abcd 0 0
0 8000 7fff 0 0
0 ffff 0000 0 0
0 0001 8001 0 0
0 a5a5 5a5a 0 0
0 0000 ffff 0 0
1 010 03 01c 10     // Wraps past the limit after 1f
1 ff0 08 fff 6      // Wraps on the 12 bit overflow
0 dead beef 0 0
0 7e81 c00c 0 0
2 0 14 0 0          // 20 frames with random out_rtr
0 5555 aaaa 0 0
2 1 0a 0 0          // 10 frames into a FIFO of 8
0 c3c3 3c3c 0 0
1 000 ff 2ff 5
0 0102 0304 0 0
f 0 0 0 0

// ==== vlog.f ====
verilog/i2s_pkg.sv
verilog/i2s_sync.sv
verilog/i2s_deserializer.sv
verilog/i2s_bist_gen.sv
verilog/i2s_fifo.sv
verilog/i2s_in.sv
test/tb_i2s_in.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the I2S input testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f vlog.f --top-module tb_i2s_in -o sim_tb_i2s_in \
    && ./obj_dir/sim_tb_i2s_in 2>&1 | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }

grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0
